// File: compile.f
design/arith_pkg.sv
design/unit_if.sv
design/alu_sequencer.sv
design/alu_comb.sv
design/mult_pipe.sv
design/div_iter.sv
design/div_sign.sv
design/arith_unit.sv
tests/tb_clock.sv
tests/arith_unit_props.sv
tests/arith_unit_tb.sv

// File: design/alu_comb.sv
// Combinational add, subtract, less-than and equality
`timescale 1ns/1ps

module alu_comb (
  unit_if.unit             bus,
  output arith_pkg::word_t result
);
  import arith_pkg::*;

  logic lt_signed;
  logic lt_unsigned;

  assign lt_signed   = $signed(bus.left) < $signed(bus.right);
  assign lt_unsigned = bus.left < bus.right;

  always_comb begin
    result = '0;
    case (bus.op)
      OP_ADD: result = bus.left + bus.right;
      OP_SUB: result = bus.left - bus.right;
      // Comparisons answer in bit 0
      OP_LT:  result[0] = bus.is_signed ? lt_signed : lt_unsigned;
      OP_EQ:  result[0] = (bus.left == bus.right);
      default: result = '0;
    endcase
  end

endmodule

// File: design/alu_sequencer.sv
// Operation registers, go/done control FSM and result capture
`timescale 1ns/1ps

module alu_sequencer (
  input  logic              clk,
  input  logic              rst,
  input  logic              go,
  input  arith_pkg::alu_op_e op,
  input  logic              is_signed,
  input  arith_pkg::word_t  left,
  input  arith_pkg::word_t  right,
  unit_if.issue             bus,
  input  arith_pkg::word_t  comb_result,
  input  arith_pkg::word_t  mult_result,
  input  logic              mult_done,
  input  arith_pkg::word_t  quotient,
  input  arith_pkg::word_t  remainder_in,
  input  logic              div_done,
  output arith_pkg::word_t  result,
  output arith_pkg::word_t  remainder,
  output logic              done
);
  import arith_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT,
    ST_DONE
  } state_e;

  state_e  state;
  alu_op_e op_q;
  logic    signed_q;
  word_t   left_q;
  word_t   right_q;
  logic    start_q;
  // One-hot age of the issued operation, used to pick our own mult_done
  logic [MULT_LAT:0] mult_track;
  logic    accept;
  logic    unit_done;

  assign accept = (state == ST_IDLE) && go;

  assign bus.left      = left_q;
  assign bus.right     = right_q;
  assign bus.op        = op_q;
  assign bus.is_signed = signed_q;
  assign bus.start     = start_q;

  assign done = (state == ST_DONE);

  // Completion of the unit selected by the registered opcode.
  // A stale mult_done or div_done from an abandoned operation is masked
  always_comb begin
    case (op_q)
      OP_MUL, OP_FMUL: unit_done = mult_done && mult_track[MULT_LAT];
      OP_DIV:          unit_done = div_done && !start_q;
      default:         unit_done = 1'b1;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= ST_IDLE;
      start_q    <= 1'b0;
      mult_track <= '0;
    end else begin
      start_q    <= accept;
      mult_track <= mult_track << 1;
      case (state)
        ST_IDLE: begin
          if (go) begin
            state      <= ST_WAIT;
            mult_track <= {{MULT_LAT{1'b0}}, 1'b1};
          end
        end
        ST_WAIT: begin
          if (!go) begin
            state <= ST_IDLE;
          end else if (unit_done) begin
            state <= ST_DONE;
          end
        end
        ST_DONE: begin
          if (!go) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      op_q     <= op;
      signed_q <= is_signed;
      left_q   <= left;
      right_q  <= right;
    end
  end

  // Result capture on completion, held through the done phase
  always_ff @(posedge clk) begin
    if (state == ST_WAIT && go && unit_done) begin
      case (op_q)
        OP_MUL, OP_FMUL: begin
          result    <= mult_result;
          remainder <= '0;
        end
        OP_DIV: begin
          result    <= quotient;
          remainder <= remainder_in;
        end
        default: begin
          result    <= comb_result;
          remainder <= '0;
        end
      endcase
    end
  end

endmodule

// File: design/arith_pkg.sv
// Arithmetic unit package: data widths, multiplier latency, word type and opcodes
package arith_pkg;

  // Operand and result width
  localparam int DATA_W = 32;

  // Q16.16 fixed-point format
  localparam int INT_W  = 16;
  localparam int FRAC_W = 16;

  // Start pulse to mult_done pulse, in cycles
  localparam int MULT_LAT = 3;

  typedef logic [DATA_W-1:0] word_t;

  typedef enum logic [2:0] {
    OP_ADD,
    OP_SUB,
    OP_LT,
    OP_EQ,
    OP_MUL,
    OP_FMUL,
    OP_DIV
  } alu_op_e;

endpackage

// File: design/arith_unit.sv
// Top level of the 32-bit arithmetic unit: sequencer, units and operation bus
`timescale 1ns/1ps

module arith_unit (
  input  logic               clk,
  input  logic               rst,
  input  logic               go,
  input  arith_pkg::alu_op_e op,
  input  logic               is_signed,
  input  arith_pkg::word_t   left,
  input  arith_pkg::word_t   right,
  output arith_pkg::word_t   result,
  output arith_pkg::word_t   remainder,
  output logic               done
);
  import arith_pkg::*;

  word_t comb_result;
  word_t mult_result;
  logic  mult_done;
  word_t div_quotient;
  word_t div_remainder;
  logic  div_done;

  unit_if bus ();

  alu_sequencer seq (
    .clk          (clk),
    .rst          (rst),
    .go           (go),
    .op           (op),
    .is_signed    (is_signed),
    .left         (left),
    .right        (right),
    .bus          (bus.issue),
    .comb_result  (comb_result),
    .mult_result  (mult_result),
    .mult_done    (mult_done),
    .quotient     (div_quotient),
    .remainder_in (div_remainder),
    .div_done     (div_done),
    .result       (result),
    .remainder    (remainder),
    .done         (done)
  );

  alu_comb comb (
    .bus    (bus.unit),
    .result (comb_result)
  );

  mult_pipe mult (
    .clk       (clk),
    .rst       (rst),
    .bus       (bus.unit),
    .product   (mult_result),
    .mult_done (mult_done)
  );

  div_sign div (
    .clk       (clk),
    .rst       (rst),
    .bus       (bus.unit),
    .quotient  (div_quotient),
    .remainder (div_remainder),
    .div_done  (div_done)
  );

endmodule

// File: design/div_iter.sv
// Unsigned restoring divider, one quotient bit per cycle
`timescale 1ns/1ps

module div_iter (
  input  logic             clk,
  input  logic             rst,
  input  logic             start,
  input  arith_pkg::word_t dividend,
  input  arith_pkg::word_t divisor,
  output arith_pkg::word_t quotient,
  output arith_pkg::word_t remainder,
  output logic             done
);
  import arith_pkg::*;

  // Partial remainder and divisor aligned to the current quotient bit
  word_t                 rem_q;
  logic [2*DATA_W-2:0]   div_q;
  word_t                 quot_q;
  word_t                 mask_q;
  logic                  running;
  logic                  step;
  logic                  finished;

  assign step      = running && (mask_q != '0);
  assign finished  = running && (mask_q == '0);
  assign quotient  = quot_q;
  assign remainder = rem_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      running <= 1'b0;
      done    <= 1'b0;
    end else if (start) begin
      running <= 1'b1;
      done    <= 1'b0;
    end else begin
      done <= finished;
      if (finished) begin
        running <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      rem_q  <= dividend;
      div_q  <= {divisor, {(DATA_W-1){1'b0}}};
      quot_q <= '0;
      mask_q <= {1'b1, {(DATA_W-1){1'b0}}};
    end else if (step) begin
      // Zero divisor always subtracts, giving all ones and the dividend back
      if (div_q <= {{(DATA_W-1){1'b0}}, rem_q}) begin
        rem_q  <= rem_q - div_q[DATA_W-1:0];
        quot_q <= quot_q | mask_q;
      end
      div_q  <= div_q >> 1;
      mask_q <= mask_q >> 1;
    end
  end

endmodule

// File: design/div_sign.sv
// Signed division wrapper with divide-by-zero bypass around div_iter
`timescale 1ns/1ps

module div_sign (
  input  logic             clk,
  input  logic             rst,
  unit_if.unit             bus,
  output arith_pkg::word_t quotient,
  output arith_pkg::word_t remainder,
  output logic             div_done
);
  import arith_pkg::*;

  logic  issue;
  logic  neg_left;
  logic  neg_right;
  logic  zero_in;
  word_t dividend_in;
  word_t divisor_in;
  logic  neg_q;
  logic  neg_r;
  logic  div_zero;
  word_t core_q;
  word_t core_r;

  assign issue     = bus.start && (bus.op == OP_DIV);
  assign neg_left  = bus.is_signed && bus.left[DATA_W-1];
  assign neg_right = bus.is_signed && bus.right[DATA_W-1];
  assign zero_in   = (bus.right == '0);

  // Raw dividend on a zero divisor so the core hands it back untouched
  assign dividend_in = (neg_left && !zero_in) ? -bus.left : bus.left;
  assign divisor_in  = neg_right ? -bus.right : bus.right;

  // Sign decisions held from start while the bus moves on
  always_ff @(posedge clk) begin
    if (issue) begin
      neg_q    <= neg_left ^ neg_right;
      neg_r    <= neg_left;
      div_zero <= zero_in;
    end
  end

  // Truncating quotient, remainder follows the dividend sign
  assign quotient  = (neg_q && !div_zero) ? -core_q : core_q;
  assign remainder = (neg_r && !div_zero) ? -core_r : core_r;

  div_iter core (
    .clk       (clk),
    .rst       (rst),
    .start     (issue),
    .dividend  (dividend_in),
    .divisor   (divisor_in),
    .quotient  (core_q),
    .remainder (core_r),
    .done      (div_done)
  );

endmodule

// File: design/mult_pipe.sv
// Three stage integer and Q16.16 multiplier, signed or unsigned
`timescale 1ns/1ps

module mult_pipe (
  input  logic             clk,
  input  logic             rst,
  unit_if.unit             bus,
  output arith_pkg::word_t product,
  output logic             mult_done
);
  import arith_pkg::*;

  logic                  issue;
  logic                  s1_valid;
  logic                  s1_fixed;
  logic                  s1_sign;
  word_t                 s1_left;
  word_t                 s1_right;
  logic [2*DATA_W-1:0]   ext_left;
  logic [2*DATA_W-1:0]   ext_right;
  logic                  s2_valid;
  logic                  s2_fixed;
  logic [2*DATA_W-1:0]   s2_prod;

  assign issue = bus.start && (bus.op == OP_MUL || bus.op == OP_FMUL);

  // Sign extension only in signed mode, so one 64-bit multiply serves both
  assign ext_left  = {{DATA_W{s1_sign & s1_left[DATA_W-1]}}, s1_left};
  assign ext_right = {{DATA_W{s1_sign & s1_right[DATA_W-1]}}, s1_right};

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid  <= 1'b0;
      s2_valid  <= 1'b0;
      mult_done <= 1'b0;
    end else begin
      s1_valid  <= issue;
      s2_valid  <= s1_valid;
      mult_done <= s2_valid;
    end
  end

  always_ff @(posedge clk) begin
    s1_left  <= bus.left;
    s1_right <= bus.right;
    s1_sign  <= bus.is_signed;
    s1_fixed <= (bus.op == OP_FMUL);
    s2_prod  <= ext_left * ext_right;
    s2_fixed <= s1_fixed;
    // Q16.16 keeps product bits 47 down to 16
    if (s2_fixed) begin
      product <= s2_prod[2*DATA_W-INT_W-1:FRAC_W];
    end else begin
      product <= s2_prod[DATA_W-1:0];
    end
  end

endmodule

// File: design/unit_if.sv
// Operation bus from the sequencer to the arithmetic units
`timescale 1ns/1ps

interface unit_if;
  import arith_pkg::*;

  word_t   left;
  word_t   right;
  alu_op_e op;
  logic    is_signed;
  // One cycle pulse per issued operation
  logic    start;

  modport issue (
    output left,
    output right,
    output op,
    output is_signed,
    output start
  );

  modport unit (
    input left,
    input right,
    input op,
    input is_signed,
    input start
  );

endinterface

// File: tests/arith_unit_props.sv
// Concurrent assertions on the arith_unit go/done handshake, with the bind into the top level
`timescale 1ns/1ps

module arith_unit_props (
  input logic             clk,
  input logic             rst,
  input logic             go,
  input logic             done,
  input arith_pkg::word_t result,
  input arith_pkg::word_t remainder
);

  // Read by the testbench at the end of the run
  int fail_count = 0;

  reset_clears_done: assert property (@(posedge clk) rst |=> !done)
  else begin
    fail_count++;
    $error("done is not low after a reset cycle");
  end

  // A new done only follows a cycle with go high
  done_needs_go: assert property (@(posedge clk) disable iff (rst)
    $rose(done) |-> $past(go))
  else begin
    fail_count++;
    $error("done rose after a cycle with go low");
  end

  hold_stable: assert property (@(posedge clk) disable iff (rst)
    (done && go) |=> ($stable(result) && $stable(remainder)))
  else begin
    fail_count++;
    $error("result or remainder changed while done and go were high");
  end

  release_clears_done: assert property (@(posedge clk) disable iff (rst)
    $fell(go) |=> !done)
  else begin
    fail_count++;
    $error("done still high one cycle after go fell");
  end

endmodule

bind arith_unit arith_unit_props protocol (
  .clk       (clk),
  .rst       (rst),
  .go        (go),
  .done      (done),
  .result    (result),
  .remainder (remainder)
);

// File: tests/arith_unit_tb.sv
// Testbench for arith_unit: LFSR stimulus, reference model, result and latency checks
`timescale 1ns/1ps

module arith_unit_tb;
  import arith_pkg::*;

  localparam int NUM_OPS        = 400;
  localparam int TIMEOUT_CYCLES = NUM_OPS * (DATA_W + 8) + 100;
  // Cycles that go stays high after done before it is released
  localparam int HOLD_CYCLES    = 2;

  logic        clk;
  logic        rst;
  logic        go;
  alu_op_e     op;
  logic        is_signed;
  word_t       left;
  word_t       right;
  word_t       result;
  word_t       remainder;
  logic        done;
  logic [31:0] lfsr_state;
  int          errors;
  int          cycles;

  tb_clock clock_gen (
    .clk (clk)
  );

  arith_unit UUT (
    .clk       (clk),
    .rst       (rst),
    .go        (go),
    .op        (op),
    .is_signed (is_signed),
    .left      (left),
    .right     (right),
    .result    (result),
    .remainder (remainder),
    .done      (done)
  );

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  // Expected result and remainder for one operation
  function automatic void model(input alu_op_e m_op, input logic sgn, input word_t a,
                                input word_t b, output word_t res, output word_t rem);
    logic [2*DATA_W-1:0] pa;
    logic [2*DATA_W-1:0] pb;
    logic [2*DATA_W-1:0] prod;
    word_t               ma;
    word_t               mb;
    pa   = sgn ? {{DATA_W{a[DATA_W-1]}}, a} : {{DATA_W{1'b0}}, a};
    pb   = sgn ? {{DATA_W{b[DATA_W-1]}}, b} : {{DATA_W{1'b0}}, b};
    prod = pa * pb;
    rem  = '0;
    case (m_op)
      OP_ADD:  res = a + b;
      OP_SUB:  res = a - b;
      OP_LT:   res = sgn ? word_t'($signed(a) < $signed(b)) : word_t'(a < b);
      OP_EQ:   res = word_t'(a == b);
      OP_MUL:  res = prod[31:0];
      OP_FMUL: res = prod[47:16];
      OP_DIV: begin
        if (b == '0) begin
          res = '1;
          rem = a;
        end else begin
          ma  = (sgn && a[DATA_W-1]) ? -a : a;
          mb  = (sgn && b[DATA_W-1]) ? -b : b;
          res = (sgn && (a[DATA_W-1] ^ b[DATA_W-1])) ? -(ma / mb) : ma / mb;
          rem = (sgn && a[DATA_W-1]) ? -(ma % mb) : ma % mb;
        end
      end
      default: res = '0;
    endcase
  endfunction

  // Raise go, wait for done, check, then release and check that done clears
  task automatic run_op(input alu_op_e op_in, input logic sgn_in, input word_t a_in,
                        input word_t b_in);
    word_t exp_res;
    word_t exp_rem;
    word_t held_res;
    word_t held_rem;
    int    edges;
    int    exp_lat;
    model(op_in, sgn_in, a_in, b_in, exp_res, exp_rem);
    case (op_in)
      OP_MUL, OP_FMUL: exp_lat = MULT_LAT + 2;
      OP_DIV:          exp_lat = 0;
      default:         exp_lat = 2;
    endcase
    op        = op_in;
    is_signed = sgn_in;
    left      = a_in;
    right     = b_in;
    go        = 1'b1;
    edges     = 0;
    do begin
      @(negedge clk);
      edges++;
    end while (!done);
    assert (result == exp_res)
    else begin
      errors++;
      $display("mismatch result: op %s signed %0b left %h right %h expected %h got %h",
               op_in.name(), sgn_in, a_in, b_in, exp_res, result);
    end
    assert (remainder == exp_rem)
    else begin
      errors++;
      $display("mismatch remainder: op %s signed %0b left %h right %h expected %h got %h",
               op_in.name(), sgn_in, a_in, b_in, exp_rem, remainder);
    end
    if (exp_lat != 0) begin
      assert (edges == exp_lat)
      else begin
        errors++;
        $display("done for %s came %0d edges after go instead of %0d",
                 op_in.name(), edges, exp_lat);
      end
    end
    // Keep go high for a while and check that done and the captured values stay put
    held_res = result;
    held_rem = remainder;
    repeat (HOLD_CYCLES) begin
      @(negedge clk);
      assert (done)
      else begin
        errors++;
        $display("done fell while go was still held high");
      end
      assert (result == held_res && remainder == held_rem)
      else begin
        errors++;
        $display("mismatch result/remainder while go held: expected %h/%h got %h/%h",
                 held_res, held_rem, result, remainder);
      end
    end
    go = 1'b0;
    @(negedge clk);
    assert (!done)
    else begin
      errors++;
      $display("done stayed high one cycle after go was dropped");
    end
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the operations did not complete", cycles);
      $display("Simulation FAILED");
      $finish;
    end
  end

  initial begin
    logic [31:0] bits;
    alu_op_e     op_draw;
    logic        sgn_draw;
    word_t       a_draw;
    word_t       b_draw;
    lfsr_state = 32'h52a2_82ed;
    errors     = 0;
    cycles     = 0;
    rst        = 1'b1;
    go         = 1'b0;
    op         = OP_ADD;
    is_signed  = 1'b0;
    left       = '0;
    right      = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i < NUM_OPS; i++) begin
      take_bits(3, bits);
      op_draw = alu_op_e'(bits[2:0] % 3'd7);
      take_bits(1, bits);
      sgn_draw = bits[0];
      take_bits(32, bits);
      a_draw = bits;
      take_bits(32, bits);
      b_draw = bits;
      // Edge values: zero divisor, min / -1, all ones, minimum value
      if (i % 16 == 15) begin
        take_bits(2, bits);
        case (bits[1:0])
          2'd0: begin
            op_draw = OP_DIV;
            b_draw  = '0;
          end
          2'd1: begin
            op_draw  = OP_DIV;
            sgn_draw = 1'b1;
            a_draw   = {1'b1, {(DATA_W-1){1'b0}}};
            b_draw   = '1;
          end
          2'd2:    a_draw = '1;
          default: b_draw = {1'b1, {(DATA_W-1){1'b0}}};
        endcase
      end
      run_op(op_draw, sgn_draw, a_draw, b_draw);
    end
    $display("Errors: %0d check, %0d protocol", errors, UUT.protocol.fail_count);
    if (errors == 0 && UUT.protocol.fail_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: tests/tb_clock.sv
// Free running testbench clock with a 4 ns period
`timescale 1ns/1ps

module tb_clock (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

endmodule
